// File: hdl/usb_rx_pkg.sv
////////////////////////////////////////
// line state, PID and packet kind types
// CRC register types, polynomials and residues
// sync pattern and oversampling rate
////////////////////////////////////////

`default_nettype none

package usb_rx_pkg;

  // line state of the pair with D+ in bit 1 and D- in bit 0
  // DT marks the clock spent waiting for both wires to settle
  typedef enum logic [2:0] {
    LINE_SE0 = 3'b000,
    LINE_K   = 3'b001,
    LINE_J   = 3'b010,
    LINE_DT  = 3'b100
  } usb_line_e;

  // the PID as sent on the wire without its check nibble
  typedef logic [3:0] usb_pid_t;

  // the low two PID bits select the packet kind
  typedef enum logic [1:0] {
    PKT_SPECIAL   = 2'b00,
    PKT_TOKEN     = 2'b01,
    PKT_HANDSHAKE = 2'b10,
    PKT_DATA      = 2'b11
  } usb_pkt_kind_e;

  typedef logic [4:0]  crc5_t;
  typedef logic [15:0] crc16_t;

  // token CRC, x^5 + x^2 + 1
  parameter crc5_t CRC5_POLY    = 5'b00101;
  parameter crc5_t CRC5_RESIDUE = 5'b01100;

  // data CRC, x^16 + x^15 + x^2 + 1
  parameter crc16_t CRC16_POLY    = 16'h8005;
  parameter crc16_t CRC16_RESIDUE = 16'h800D;

  // last six sync symbols K J K J K K with the oldest symbol in the top bits
  parameter logic [11:0] SYNC_PATTERN = 12'b01_10_01_10_01_01;

  // the line is sampled four times per full-speed bit
  parameter int unsigned SAMPLES_PER_BIT = 4;

endpackage

`default_nettype wire

// File: hdl/usb_line_recovery.sv
////////////////////////////////////////
// D+/D- line state recovery with a
// transition state and bit phase tracking
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_line_recovery
  import usb_rx_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      usb_dp_i,
  input  logic      usb_dn_i,
  output usb_line_e line_state_o,
  output logic      sample_valid_o,
  output logic      bit_strobe_o
);

  localparam int unsigned PHASE_W = $clog2(SAMPLES_PER_BIT);

  usb_line_e          line_state_q, line_state_d;
  logic [1:0]         dpair;
  logic [PHASE_W-1:0] bit_phase_q, bit_phase_d;

  ////////////////////////////////////////
  // line state
  ////////////////////////////////////////

  assign dpair = {usb_dp_i, usb_dn_i};

  // one wire of the pair may switch a clock ahead of the other
  // so any change first parks the state in DT for one clock
  // and the pair is read again once both wires have settled
  always_comb begin
    line_state_d = line_state_q;
    if (line_state_q == LINE_DT) begin
      // an SE1 on the pair passes through as an undefined code
      line_state_d = usb_line_e'({1'b0, dpair});
    end else if (dpair != line_state_q[1:0]) begin
      line_state_d = LINE_DT;
    end
  end

  ////////////////////////////////////////
  // clock recovery
  ////////////////////////////////////////

  // every transition realigns the phase to the sender's bit clock
  // phase 1 is the middle of the bit and the safest point to sample
  assign bit_phase_d = (line_state_q == LINE_DT) ? '0 : bit_phase_q + PHASE_W'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_state_q <= LINE_SE0;
      bit_phase_q  <= '0;
    end else begin
      line_state_q <= line_state_d;
      bit_phase_q  <= bit_phase_d;
    end
  end

  assign line_state_o   = line_state_q;
  assign sample_valid_o = (bit_phase_q == PHASE_W'(1));
  assign bit_strobe_o   = (bit_phase_q == PHASE_W'(2));

  // a settled pair must leave DT after a single clock
  dt_single_cycle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (line_state_q == LINE_DT) |=> (line_state_q != LINE_DT));

endmodule

`default_nettype wire

// File: hdl/usb_bit_decoder.sv
////////////////////////////////////////
// sync and EOP framing, NRZI decoding
// bit unstuffing and PID capture
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_bit_decoder
  import usb_rx_pkg::*;
#(
  parameter int unsigned STUFF_LIMIT = 6
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cfg_eop_single_bit_i,
  input  usb_line_e line_state_i,
  input  logic      sample_valid_i,
  output logic      pkt_start_o,
  output logic      pkt_end_o,
  output logic      bit_valid_o,
  output logic      bit_value_o,
  output usb_pid_t  pid_o,
  output logic      pid_ok_o,
  output logic      bitstuff_err_o
);

  localparam int unsigned CNT_W = $clog2(STUFF_LIMIT + 1);

  logic [11:0]      line_hist_q, line_hist_d;
  logic             in_pkt_q, in_pkt_d;
  logic             see_eop, pkt_start, pkt_end;
  logic             sym_ok, din, dvalid_raw, dvalid;
  logic [CNT_W-1:0] ones_q, ones_d;
  logic             stuff_hit, stuff_err_q, stuff_err_d;
  logic [8:0]       full_pid_q, full_pid_d;
  logic             pid_done;

  ////////////////////////////////////////
  // framing
  ////////////////////////////////////////

  // two bits per sampled symbol and the newest symbol in the low bits
  assign line_hist_d = sample_valid_i ? {line_hist_q[9:0], line_state_i[1:0]} : line_hist_q;

  // a single SE0 bit ends the packet only when configured so
  // and a stuff error aborts the packet at the next sample
  assign see_eop = (cfg_eop_single_bit_i && (line_hist_q[1:0] == 2'b00)) ||
                   (line_hist_q[3:0] == 4'b0000) || stuff_err_q;

  always_comb begin
    in_pkt_d = in_pkt_q;
    if (sample_valid_i) begin
      if (!in_pkt_q && (line_hist_q == SYNC_PATTERN)) begin
        in_pkt_d = 1'b1;
      end else if (in_pkt_q && see_eop) begin
        in_pkt_d = 1'b0;
      end
    end
  end

  // the start pulse coincides with the first PID symbol entering the history
  assign pkt_start = in_pkt_d & ~in_pkt_q;
  assign pkt_end   = ~in_pkt_d & in_pkt_q;

  ////////////////////////////////////////
  // NRZI decode and bit unstuffing
  ////////////////////////////////////////

  // a bit is decoded only between two J or K symbols
  // an unchanged symbol is a one and a toggle is a zero
  assign sym_ok     = (^line_hist_q[3:2]) & (^line_hist_q[1:0]);
  assign din        = (line_hist_q[3:2] == line_hist_q[1:0]);
  assign dvalid_raw = in_pkt_q & sample_valid_i & sym_ok;

  // after STUFF_LIMIT ones the next bit must be a stuffed zero and is dropped
  assign stuff_hit = (ones_q == CNT_W'(STUFF_LIMIT));
  assign dvalid    = dvalid_raw & ~stuff_hit;

  always_comb begin
    ones_d = ones_q;
    if (pkt_start) begin
      ones_d = '0;
    end else if (dvalid_raw) begin
      if (!din) begin
        ones_d = '0;
      end else if (!stuff_hit) begin
        ones_d = ones_q + CNT_W'(1);
      end
    end
  end

  // a one where the stuffed zero belongs is remembered for the whole packet
  assign stuff_err_d = pkt_start ? 1'b0 : (stuff_err_q | (dvalid_raw & din & stuff_hit));

  ////////////////////////////////////////
  // PID capture
  ////////////////////////////////////////

  // the sentinel reaches bit 0 once all eight PID bits are in
  assign pid_done = full_pid_q[0];

  always_comb begin
    full_pid_d = full_pid_q;
    if (pkt_start) begin
      full_pid_d = 9'b1_0000_0000;
    end else if (dvalid && !pid_done) begin
      full_pid_d = {din, full_pid_q[8:1]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_hist_q <= {6{LINE_K[1:0]}};
      in_pkt_q    <= 1'b0;
      ones_q      <= '0;
      stuff_err_q <= 1'b0;
      full_pid_q  <= '0;
    end else begin
      line_hist_q <= line_hist_d;
      in_pkt_q    <= in_pkt_d;
      ones_q      <= ones_d;
      stuff_err_q <= stuff_err_d;
      full_pid_q  <= full_pid_d;
    end
  end

  assign pkt_start_o    = pkt_start;
  assign pkt_end_o      = pkt_end;
  assign bit_valid_o    = dvalid & pid_done;
  assign bit_value_o    = din;
  assign pid_o          = full_pid_q[4:1];
  assign pid_ok_o       = (full_pid_q[4:1] == ~full_pid_q[8:5]);
  assign bitstuff_err_o = stuff_err_q;

  start_end_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(pkt_start && pkt_end));

endmodule

`default_nettype wire

// File: hdl/usb_crc_checker.sv
////////////////////////////////////////
// serial CRC register with residue check
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_crc_checker #(
  parameter type  crc_t   = logic [4:0],
  parameter crc_t POLY    = '0,
  parameter crc_t RESIDUE = '0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic pkt_start_i,
  input  logic bit_valid_i,
  input  logic bit_value_i,
  output logic crc_ok_o
);

  localparam int unsigned W = $bits(crc_t);

  crc_t crc_q, crc_d;
  logic feedback;

  // the incoming bit meets the register's top bit
  // and a mismatch folds the polynomial back in
  assign feedback = bit_value_i ^ crc_q[W-1];

  always_comb begin
    crc_d = crc_q;
    if (pkt_start_i) begin
      crc_d = '1;
    end else if (bit_valid_i) begin
      crc_d = {crc_q[W-2:0], 1'b0} ^ (feedback ? POLY : '0);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc_q <= '1;
    end else begin
      crc_q <= crc_d;
    end
  end

  // with the sent CRC shifted in as well the register lands on the fixed residue
  assign crc_ok_o = (crc_q == RESIDUE);

endmodule

`default_nettype wire

// File: hdl/usb_field_parser.sv
////////////////////////////////////////
// packet kind, token fields, data byte
// deserializer and payload length flags
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_field_parser
  import usb_rx_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          pkt_start_i,
  input  logic          bit_valid_i,
  input  logic          bit_value_i,
  input  usb_pid_t      pid_i,
  output usb_pkt_kind_e pkt_kind_o,
  output logic [6:0]    addr_o,
  output logic [3:0]    endp_o,
  output logic [10:0]   frame_num_o,
  output logic          rx_data_put_o,
  output logic [7:0]    rx_data_o,
  output logic          len_token_o,
  output logic          len_data_o,
  output logic          len_handshake_o
);

  usb_pkt_kind_e pkt_kind;
  logic          is_token, is_data;
  logic [11:0]   token_q;
  logic          token_done;
  logic [8:0]    rx_buf_q;
  logic          rx_buf_full;
  logic [3:0]    len_cnt_q;
  logic          len16_q, len_over_q;

  assign pkt_kind = usb_pkt_kind_e'(pid_i[1:0]);
  assign is_token = (pkt_kind == PKT_TOKEN);
  assign is_data  = (pkt_kind == PKT_DATA);

  ////////////////////////////////////////
  // token payload and data bytes
  ////////////////////////////////////////

  // both shift registers fill from the top and their sentinel marks completion
  assign token_done  = token_q[0];
  assign rx_buf_full = rx_buf_q[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      token_q     <= '0;
      addr_o      <= '0;
      endp_o      <= '0;
      frame_num_o <= '0;
      rx_buf_q    <= '0;
    end else begin
      if (pkt_start_i) begin
        token_q <= 12'b1000_0000_0000;
      end else if (bit_valid_i && is_token && !token_done) begin
        token_q <= {bit_value_i, token_q[11:1]};
      end
      // the eleven payload bits are an address and endpoint or a SOF frame number
      if (token_done && is_token) begin
        addr_o      <= token_q[7:1];
        endp_o      <= token_q[11:8];
        frame_num_o <= token_q[11:1];
      end
      // the two CRC16 bytes leave the deserializer like any other byte
      if (pkt_start_i || rx_buf_full) begin
        rx_buf_q <= 9'b1_0000_0000;
      end else if (bit_valid_i && is_data) begin
        rx_buf_q <= {bit_value_i, rx_buf_q[8:1]};
      end
    end
  end

  ////////////////////////////////////////
  // payload length
  ////////////////////////////////////////

  // the low four bits count freely and two flags record reaching 16 and going past it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      len_cnt_q  <= '0;
      len16_q    <= 1'b0;
      len_over_q <= 1'b0;
    end else if (pkt_start_i) begin
      len_cnt_q  <= '0;
      len16_q    <= 1'b0;
      len_over_q <= 1'b0;
    end else if (bit_valid_i) begin
      len_cnt_q  <= len_cnt_q + 4'd1;
      len16_q    <= len16_q | (&len_cnt_q);
      len_over_q <= len_over_q | len16_q;
    end
  end

  assign pkt_kind_o      = pkt_kind;
  assign rx_data_put_o   = rx_buf_full;
  assign rx_data_o       = rx_buf_q[8:1];
  assign len_token_o     = len16_q & ~len_over_q & (len_cnt_q == 4'd0);
  // data payloads must end on a byte boundary
  assign len_data_o      = len16_q & (len_cnt_q[2:0] == 3'd0);
  assign len_handshake_o = ~len16_q & (len_cnt_q == 4'd0);

endmodule

`default_nettype wire

// File: hdl/usb_packet_check.sv
////////////////////////////////////////
// packet validity and error flags
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_packet_check
  import usb_rx_pkg::*;
(
  input  logic          pkt_end_i,
  input  usb_pkt_kind_e pkt_kind_i,
  input  logic          pid_ok_i,
  input  logic          bitstuff_err_i,
  input  logic          crc5_ok_i,
  input  logic          crc16_ok_i,
  input  logic          len_token_i,
  input  logic          len_data_i,
  input  logic          len_handshake_i,
  output logic          valid_packet_o,
  output logic          crc5_error_o,
  output logic          crc16_error_o,
  output logic          pid_error_o,
  output logic          bitstuff_error_o
);

  logic is_token, is_data, is_handshake;

  always_comb begin
    is_token     = (pkt_kind_i == PKT_TOKEN);
    is_data      = (pkt_kind_i == PKT_DATA);
    is_handshake = (pkt_kind_i == PKT_HANDSHAKE);

    // each kind has its own length rule and CRC
    // handshakes carry no payload and so no CRC
    valid_packet_o = pid_ok_i && !bitstuff_err_i &&
                     ((is_handshake && len_handshake_i) ||
                      (is_data && len_data_i && crc16_ok_i) ||
                      (is_token && len_token_i && crc5_ok_i));

    // error flags pulse together with the end of the packet
    crc5_error_o     = pkt_end_i & is_token & ~crc5_ok_i;
    crc16_error_o    = pkt_end_i & is_data & ~crc16_ok_i;
    pid_error_o      = pkt_end_i & ~pid_ok_i;
    bitstuff_error_o = pkt_end_i & bitstuff_err_i;

    crc_err_excl_a: assert (!(crc5_error_o && crc16_error_o))
      else $error("token and data CRC errors raised for one packet");
  end

endmodule

`default_nettype wire

// File: hdl/usb_fs_rx_top.sv
////////////////////////////////////////
// full-speed USB packet receiver top level
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module usb_fs_rx_top
  import usb_rx_pkg::*;
#(
  parameter int unsigned STUFF_LIMIT = 6
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        usb_dp_i,
  input  logic        usb_dn_i,
  input  logic        cfg_eop_single_bit_i,
  output logic        bit_strobe_o,
  output logic        pkt_start_o,
  output logic        pkt_end_o,
  output usb_pid_t    pid_o,
  output logic        valid_pid_o,
  output logic [6:0]  addr_o,
  output logic [3:0]  endp_o,
  output logic [10:0] frame_num_o,
  output logic        rx_data_put_o,
  output logic [7:0]  rx_data_o,
  output logic        valid_packet_o,
  output logic        crc5_error_o,
  output logic        crc16_error_o,
  output logic        pid_error_o,
  output logic        bitstuff_error_o
);

  usb_line_e     line_state;
  logic          sample_valid;
  logic          pkt_start, pkt_end;
  logic          bit_valid, bit_value;
  logic          pid_ok, bitstuff_err;
  logic          crc5_ok, crc16_ok;
  usb_pkt_kind_e pkt_kind;
  logic          len_token, len_data, len_handshake;

  usb_line_recovery u_line_recovery (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .usb_dp_i       (usb_dp_i),
    .usb_dn_i       (usb_dn_i),
    .line_state_o   (line_state),
    .sample_valid_o (sample_valid),
    .bit_strobe_o   (bit_strobe_o)
  );

  usb_bit_decoder #(
    .STUFF_LIMIT (STUFF_LIMIT)
  ) u_bit_decoder (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cfg_eop_single_bit_i (cfg_eop_single_bit_i),
    .line_state_i         (line_state),
    .sample_valid_i       (sample_valid),
    .pkt_start_o          (pkt_start),
    .pkt_end_o            (pkt_end),
    .bit_valid_o          (bit_valid),
    .bit_value_o          (bit_value),
    .pid_o                (pid_o),
    .pid_ok_o             (pid_ok),
    .bitstuff_err_o       (bitstuff_err)
  );

  // both CRCs run over every payload and the packet kind picks the one that counts
  usb_crc_checker #(
    .crc_t   (crc5_t),
    .POLY    (CRC5_POLY),
    .RESIDUE (CRC5_RESIDUE)
  ) u_crc5 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pkt_start_i (pkt_start),
    .bit_valid_i (bit_valid),
    .bit_value_i (bit_value),
    .crc_ok_o    (crc5_ok)
  );

  usb_crc_checker #(
    .crc_t   (crc16_t),
    .POLY    (CRC16_POLY),
    .RESIDUE (CRC16_RESIDUE)
  ) u_crc16 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pkt_start_i (pkt_start),
    .bit_valid_i (bit_valid),
    .bit_value_i (bit_value),
    .crc_ok_o    (crc16_ok)
  );

  usb_field_parser u_field_parser (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pkt_start_i     (pkt_start),
    .bit_valid_i     (bit_valid),
    .bit_value_i     (bit_value),
    .pid_i           (pid_o),
    .pkt_kind_o      (pkt_kind),
    .addr_o          (addr_o),
    .endp_o          (endp_o),
    .frame_num_o     (frame_num_o),
    .rx_data_put_o   (rx_data_put_o),
    .rx_data_o       (rx_data_o),
    .len_token_o     (len_token),
    .len_data_o      (len_data),
    .len_handshake_o (len_handshake)
  );

  usb_packet_check u_packet_check (
    .pkt_end_i        (pkt_end),
    .pkt_kind_i       (pkt_kind),
    .pid_ok_i         (pid_ok),
    .bitstuff_err_i   (bitstuff_err),
    .crc5_ok_i        (crc5_ok),
    .crc16_ok_i       (crc16_ok),
    .len_token_i      (len_token),
    .len_data_i       (len_data),
    .len_handshake_i  (len_handshake),
    .valid_packet_o   (valid_packet_o),
    .crc5_error_o     (crc5_error_o),
    .crc16_error_o    (crc16_error_o),
    .pid_error_o      (pid_error_o),
    .bitstuff_error_o (bitstuff_error_o)
  );

  assign pkt_start_o = pkt_start;
  assign pkt_end_o   = pkt_end;
  assign valid_pid_o = pid_ok;

endmodule

`default_nettype wire

// File: verif/usb_rx_stim.svh
////////////////////////////////////////
// xorshift random source, CRC model
// bit stuffing, NRZI coding and line driving
////////////////////////////////////////

`ifndef USB_RX_STIM_SVH
`define USB_RX_STIM_SVH

// line symbols with D+ in bit 1 and D- in bit 0
localparam logic [1:0] SYM_SE0 = 2'b00;
localparam logic [1:0] SYM_K   = 2'b01;
localparam logic [1:0] SYM_J   = 2'b10;

// 32-bit xorshift that advances the shared state on every call
function automatic logic [31:0] next_random();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// fields go on the wire with their least significant bit first
function automatic void append_bits(input logic [15:0] value, input int width);
  for (int i = 0; i < width; i++) begin
    pay_bits.push_back(value[i]);
  end
endfunction

// the register is preset to ones and fed from its top bit
// the result goes out inverted with the highest coefficient first
// flip_idx corrupts one CRC bit, and -1 leaves the CRC intact
function automatic void append_crc(input int width, input logic [15:0] poly,
                                   input int flip_idx);
  logic [15:0] crc;
  logic        fb;
  crc = 16'hFFFF;
  foreach (pay_bits[i]) begin
    fb  = pay_bits[i] ^ crc[width-1];
    crc = (crc << 1) ^ (fb ? poly : 16'h0000);
  end
  for (int i = width - 1; i >= 0; i--) begin
    pay_bits.push_back(~crc[i] ^ (i == flip_idx));
  end
endfunction

// one symbol is held for a whole bit time
task automatic send_symbol(input logic [1:0] sym);
  @(posedge clk);
  usb_dp <= sym[1];
  usb_dn <= sym[0];
  repeat (SAMPLES_PER_BIT - 1) @(posedge clk);
endtask

// idle and sync first, then PID and payload, then EOP and idle J
// a zero toggles the line and a one keeps it
task automatic send_packet(input logic [7:0] pid_byte, input bit stuff_en);
  logic       all_bits[$];
  logic [1:0] sym;
  int         ones;
  all_bits = {};
  for (int i = 0; i < 8; i++) begin
    all_bits.push_back(pid_byte[i]);
  end
  foreach (pay_bits[i]) begin
    all_bits.push_back(pay_bits[i]);
  end
  repeat (2) send_symbol(SYM_J);
  repeat (3) begin
    send_symbol(SYM_K);
    send_symbol(SYM_J);
  end
  send_symbol(SYM_K);
  send_symbol(SYM_K);
  sym  = SYM_K;
  ones = 0;
  foreach (all_bits[i]) begin
    if (!all_bits[i]) begin
      sym = ~sym;
    end
    send_symbol(sym);
    ones = all_bits[i] ? ones + 1 : 0;
    // the run of ones is counted from the first PID bit
    if (stuff_en && ones == STUFF_LIMIT) begin
      sym  = ~sym;
      send_symbol(sym);
      ones = 0;
    end
  end
  repeat (cfg_eop_single ? 1 : 2) send_symbol(SYM_SE0);
  repeat (3) send_symbol(SYM_J);
endtask

`endif

// File: verif/tb_usb_fs_rx.sv
////////////////////////////////////////
// testbench for the full-speed receiver
// random packets checked against a model
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_usb_fs_rx
  import usb_rx_pkg::*;
();

  localparam int STUFF_LIMIT = 6;
  localparam int END_TIMEOUT = 200;

  // flag order is valid, crc5, crc16, pid, bitstuff
  localparam logic [4:0] FLG_VALID = 5'b10000;
  localparam logic [4:0] FLG_CRC5  = 5'b01000;
  localparam logic [4:0] FLG_CRC16 = 5'b00100;
  localparam logic [4:0] FLG_PID   = 5'b00010;

  logic        clk, rst_n;
  logic        usb_dp, usb_dn, cfg_eop_single;
  logic        bit_strobe, pkt_start, pkt_end;
  usb_pid_t    pid;
  logic        valid_pid;
  logic [6:0]  addr;
  logic [3:0]  endp;
  logic [10:0] frame_num;
  logic        rx_data_put;
  logic [7:0]  rx_data;
  logic        valid_packet, crc5_error, crc16_error, pid_error, bitstuff_error;

  // model state and the outputs captured at each end of packet
  logic [31:0] rng_state;
  logic        pay_bits[$];
  logic [7:0]  rx_bytes[$];
  int          end_count, errors, checks;
  logic [4:0]  cap_flags;
  usb_pid_t    cap_pid;
  logic        cap_valid_pid;
  logic [6:0]  cap_addr;
  logic [3:0]  cap_endp;
  logic [10:0] cap_frame;

  // inside a packet every symbol lasts exactly one bit time
  logic        in_window;
  int          strobe_gap;

  `include "usb_rx_stim.svh"

  usb_fs_rx_top #(
    .STUFF_LIMIT (STUFF_LIMIT)
  ) i_dut (
    .clk_i                (clk),
    .rst_ni               (rst_n),
    .usb_dp_i             (usb_dp),
    .usb_dn_i             (usb_dn),
    .cfg_eop_single_bit_i (cfg_eop_single),
    .bit_strobe_o         (bit_strobe),
    .pkt_start_o          (pkt_start),
    .pkt_end_o            (pkt_end),
    .pid_o                (pid),
    .valid_pid_o          (valid_pid),
    .addr_o               (addr),
    .endp_o               (endp),
    .frame_num_o          (frame_num),
    .rx_data_put_o        (rx_data_put),
    .rx_data_o            (rx_data),
    .valid_packet_o       (valid_packet),
    .crc5_error_o         (crc5_error),
    .crc16_error_o        (crc16_error),
    .pid_error_o          (pid_error),
    .bitstuff_error_o     (bitstuff_error)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  ////////////////////////////////////////
  // monitor
  ////////////////////////////////////////

  // the falling edge sits in the middle of the cycle where outputs are settled
  always @(negedge clk) begin
    if (rx_data_put) begin
      rx_bytes.push_back(rx_data);
    end
    if (pkt_end) begin
      cap_flags     = {valid_packet, crc5_error, crc16_error, pid_error, bitstuff_error};
      cap_pid       = pid;
      cap_valid_pid = valid_pid;
      cap_addr      = addr;
      cap_endp      = endp;
      cap_frame     = frame_num;
      end_count++;
    end
    // the bit strobe must repeat once per bit while the packet is on the line
    if (pkt_start) begin
      in_window = 1'b1;
    end
    if (in_window && rst_n) begin
      if (strobe_gap >= 0) begin
        strobe_gap++;
      end
      if (bit_strobe) begin
        if (strobe_gap > 0) begin
          checks++;
          if (strobe_gap != SAMPLES_PER_BIT) begin
            errors++;
            $display("[FAIL] bit strobe period: expected %0d, actual %0d",
                     SAMPLES_PER_BIT, strobe_gap);
          end
        end
        strobe_gap = 0;
      end
    end else begin
      strobe_gap = -1;
    end
    if (pkt_end || !rst_n) begin
      in_window = 1'b0;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // the end of packet may already have come while the line was still driven
  task automatic send_and_wait(input string name, input logic [7:0] pid_byte,
                               input bit stuff_en);
    int seen;
    int cycles;
    seen     = end_count;
    rx_bytes = {};
    send_packet(pid_byte, stuff_en);
    cycles = 0;
    while (end_count == seen && cycles < END_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (end_count == seen) begin
      errors++;
      $display("%s: no end of packet within %0d clocks", name, END_TIMEOUT);
    end
  endtask

  // token field is the address then the endpoint, SOF field is the frame number
  task automatic run_token(input string name, input usb_pid_t p,
                           input logic [10:0] field, input int flip_idx);
    pay_bits = {};
    append_bits(16'(field), 11);
    append_crc(5, 16'(CRC5_POLY), flip_idx);
    send_and_wait(name, {~p, p}, 1'b1);
    check_value({name, " flags"}, 32'((flip_idx < 0) ? FLG_VALID : FLG_CRC5),
                32'(cap_flags));
    check_value({name, " pid"}, 32'(p), 32'(cap_pid));
    if (p == 4'b0101) begin
      check_value({name, " frame"}, 32'(field), 32'(cap_frame));
    end else begin
      check_value({name, " addr"}, 32'(field[6:0]), 32'(cap_addr));
      check_value({name, " endp"}, 32'(field[10:7]), 32'(cap_endp));
    end
  endtask

  // the CRC bytes leave the receiver as bytes too, so the model expects them
  task automatic run_data(input string name, input usb_pid_t p, input int nbytes,
                          input bit force_ff, input int flip_idx);
    logic [31:0] r;
    logic [7:0]  b;
    logic [7:0]  exp_bytes[$];
    pay_bits = {};
    for (int i = 0; i < nbytes; i++) begin
      r = next_random();
      b = (force_ff || r[10:9] == 2'd0) ? 8'hFF : r[7:0];
      append_bits(16'(b), 8);
    end
    append_crc(16, CRC16_POLY, flip_idx);
    foreach (pay_bits[i]) begin
      b = {pay_bits[i], b[7:1]};
      if (i % 8 == 7) begin
        exp_bytes.push_back(b);
      end
    end
    send_and_wait(name, {~p, p}, 1'b1);
    check_value({name, " flags"}, 32'((flip_idx < 0) ? FLG_VALID : FLG_CRC16),
                32'(cap_flags));
    check_value({name, " pid"}, 32'(p), 32'(cap_pid));
    if (flip_idx < 0) begin
      check_value({name, " byte count"}, 32'(exp_bytes.size()), 32'(rx_bytes.size()));
      for (int i = 0; i < exp_bytes.size() && i < rx_bytes.size(); i++) begin
        check_value({name, " byte"}, 32'(exp_bytes[i]), 32'(rx_bytes[i]));
      end
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    usb_pid_t    p;
    logic [31:0] r;
    rng_state      = 32'd66;
    errors         = 0;
    checks         = 0;
    end_count      = 0;
    in_window      = 1'b0;
    strobe_gap     = -1;
    usb_dp         = 1'b1;
    usb_dn         = 1'b0;
    cfg_eop_single = 1'b0;
    rst_n          = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // OUT, IN and SETUP tokens with random address and endpoint
    for (int n = 0; n < 6; n++) begin
      r = next_random();
      case (r[17:16])
        2'd0:    p = 4'b0001;
        2'd1:    p = 4'b1001;
        default: p = 4'b1101;
      endcase
      run_token("token", p, r[10:0], -1);
    end
    for (int n = 0; n < 2; n++) begin
      r = next_random();
      run_token("sof", 4'b0101, r[10:0], -1);
    end

    // DATA0 and DATA1 with 0 to 8 bytes, the first one all ones to force stuffing
    for (int n = 0; n < 8; n++) begin
      r = next_random();
      p = r[4] ? 4'b1011 : 4'b0011;
      run_data("data", p, (n == 1) ? 0 : (n == 0) ? 8 : int'(r[31:16] % 16'd9),
               n == 0, -1);
    end

    r = next_random();
    run_token("bad crc5", 4'b0001, r[10:0], 2);
    run_data("bad crc16", 4'b0011, 4, 1'b0, 9);

    // ACK with a check nibble that is not the complement
    pay_bits = {};
    send_and_wait("bad pid", 8'h22, 1'b1);
    check_value("bad pid flags", 32'(FLG_PID), 32'(cap_flags));
    check_value("bad pid valid_pid", 32'd0, 32'(cap_valid_pid));

    // sixteen ones sent without any stuffed zero
    pay_bits = {};
    append_bits(16'hFFFF, 16);
    send_and_wait("bitstuff", 8'hC3, 1'b0);
    check_value("bitstuff error", 32'd1, 32'(cap_flags[0]));
    check_value("bitstuff valid", 32'd0, 32'(cap_flags[4]));

    pay_bits = {};
    send_and_wait("ack", 8'hD2, 1'b1);
    check_value("ack flags", 32'(FLG_VALID), 32'(cap_flags));
    check_value("ack pid", 32'h2, 32'(cap_pid));
    @(posedge clk);
    cfg_eop_single <= 1'b1;
    send_and_wait("ack short eop", 8'hD2, 1'b1);
    check_value("ack short eop flags", 32'(FLG_VALID), 32'(cap_flags));

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verif
hdl/usb_rx_pkg.sv
hdl/usb_line_recovery.sv
hdl/usb_bit_decoder.sv
hdl/usb_crc_checker.sv
hdl/usb_field_parser.sv
hdl/usb_packet_check.sv
hdl/usb_fs_rx_top.sv
verif/tb_usb_fs_rx.sv

// File: run.sh
#!/bin/sh
# build the receiver and its testbench with Verilator and run the simulation
# the run fails when the build or the simulation fails or the log reports failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_usb_fs_rx -o tb_usb_fs_rx
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_usb_fs_rx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi

exit 0
